// File: mem_subsystem.f
mem_pkg.sv
mem_bus_if.sv
mem_controller.sv
bank_decoder.sv
memory_bank.sv
bank_response.sv
mem_subsystem.sv
tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - files:
      - mem_pkg.sv
      - mem_bus_if.sv
      - mem_controller.sv
      - bank_decoder.sv
      - memory_bank.sv
      - bank_response.sv
      - mem_subsystem.sv
  - target: test
    files:
      - tb_mem_subsystem.sv

// File: tb_mem_subsystem.sv
// Directed testbench for the memory subsystem, reference model, compare tasks and watchdog

module tb_mem_subsystem import mem_pkg::*; ();

    localparam int NUM_BANKS      = 4;
    localparam int WORDS_PER_BANK = 64;
    localparam int BANK_WAIT      = 2;
    localparam int RESET_CYCLES   = 4;
    localparam int CYCLES_PER_REQ = 200;

    logic  clk_i;
    logic  reset;
    logic  fetch_req;
    logic  fetch_we;
    addr_t fetch_addr;
    data_t fetch_wdata;
    data_t fetch_rdata;
    logic  fetch_rvalid;
    logic  exec_req;
    logic  exec_we;
    addr_t exec_addr;
    data_t exec_wdata;
    data_t exec_rdata;
    logic  exec_rvalid;
    logic  stall;

    // Reference memory where unwritten words read as zero
    data_t model [addr_t];
    int    requests_issued = 0;

    mem_subsystem #(
        .NUM_BANKS      (NUM_BANKS),
        .WORDS_PER_BANK (WORDS_PER_BANK),
        .BANK_WAIT      (BANK_WAIT)
    ) DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // Checks and helpers
    //////////////////////////////////////////////////

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(string name, data_t actual, data_t expected);
        if (actual !== expected) begin
            $display("error: time %0t signal %s expected %h got %h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("error: time %0t signal %s expected %b got %b",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic require_that(logic cond, string what);
        if (!cond) begin
            $display("%s at time %0t", what, $time);
            abort_run();
        end
    endtask

    function automatic data_t expected_word(addr_t addr);
        return model.exists(addr) ? model[addr] : '0;
    endfunction

    function automatic addr_t addr_of(int word);
        return addr_t'(word * 4);
    endfunction

    task automatic drive_port(port_e port, logic req, logic we, addr_t addr, data_t wdata);
        if (port == PORT_EXEC) begin
            exec_req   = req;
            exec_we    = we;
            exec_addr  = addr;
            exec_wdata = wdata;
        end else begin
            fetch_req   = req;
            fetch_we    = we;
            fetch_addr  = addr;
            fetch_wdata = wdata;
        end
    endtask

    task automatic wait_idle();
        while (stall) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // One request on one port, held for the sampling edge only
    task automatic single_access(port_e port, logic we, addr_t addr, data_t wdata);
        string pname;
        string other;
        logic  got_read;
        data_t expected;
        pname    = (port == PORT_EXEC) ? "exec" : "fetch";
        other    = (port == PORT_EXEC) ? "fetch_rvalid" : "exec_rvalid";
        got_read = 1'b0;
        expected = expected_word(addr);
        if (we) model[addr] = wdata;
        wait_idle();
        drive_port(port, 1'b1, we, addr, wdata);
        @(posedge clk_i);
        #1;
        drive_port(port, 1'b0, 1'b0, '0, '0);
        requests_issued++;
        while (stall) begin
            @(posedge clk_i);
            #1;
            check_bit(other, (port == PORT_EXEC) ? fetch_rvalid : exec_rvalid, 1'b0);
            if ((port == PORT_EXEC) ? exec_rvalid : fetch_rvalid) begin
                got_read = 1'b1;
                if (!we) check_data({pname, "_rdata"},
                    (port == PORT_EXEC) ? exec_rdata : fetch_rdata, expected);
            end
        end
        require_that(got_read == !we,
            $sformatf("%s access with we=%b ended with rvalid seen=%b", pname, we, got_read));
    endtask

    // Both ports in one cycle with execute served first
    task automatic double_access(logic exec_w, addr_t exec_a, data_t exec_d,
                                 logic fetch_w, addr_t fetch_a, data_t fetch_d);
        logic  exec_seen;
        logic  fetch_seen;
        data_t exec_exp;
        data_t fetch_exp;
        exec_seen  = 1'b0;
        fetch_seen = 1'b0;
        exec_exp   = expected_word(exec_a);
        if (exec_w) model[exec_a] = exec_d;
        fetch_exp  = expected_word(fetch_a);
        if (fetch_w) model[fetch_a] = fetch_d;
        wait_idle();
        drive_port(PORT_EXEC, 1'b1, exec_w, exec_a, exec_d);
        drive_port(PORT_FETCH, 1'b1, fetch_w, fetch_a, fetch_d);
        @(posedge clk_i);
        #1;
        drive_port(PORT_EXEC, 1'b0, 1'b0, '0, '0);
        drive_port(PORT_FETCH, 1'b0, 1'b0, '0, '0);
        requests_issued += 2;
        while (stall) begin
            @(posedge clk_i);
            #1;
            if (exec_rvalid) begin
                require_that(!fetch_seen, "exec read data came after fetch read data");
                require_that(stall, "stall fell before the held fetch access ran");
                exec_seen = 1'b1;
                check_data("exec_rdata", exec_rdata, exec_exp);
            end
            if (fetch_rvalid) begin
                fetch_seen = 1'b1;
                check_data("fetch_rdata", fetch_rdata, fetch_exp);
            end
        end
        require_that(exec_seen == !exec_w, "exec side of a double request had a wrong rvalid");
        require_that(fetch_seen == !fetch_w, "fetch side of a double request had a wrong rvalid");
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic reset_state();
        check_bit("stall", stall, 1'b0);
        check_bit("fetch_rvalid", fetch_rvalid, 1'b0);
        check_bit("exec_rvalid", exec_rvalid, 1'b0);
    endtask

    task automatic one_port_traffic(port_e port, int words [6]);
        foreach (words[i]) single_access(port, 1'b1, addr_of(words[i]), $urandom());
        foreach (words[i]) single_access(port, 1'b0, addr_of(words[i]), '0);
    endtask

    task automatic double_requests();
        double_access(1'b0, addr_of(5), '0, 1'b0, addr_of(3), '0);
        double_access(1'b1, addr_of(64), $urandom(), 1'b0, addr_of(17), '0);
        double_access(1'b0, addr_of(64), '0, 1'b1, addr_of(42), $urandom());
        single_access(PORT_FETCH, 1'b0, addr_of(42), '0);
    endtask

    task automatic bank_spread();
        int order [$];
        int w;
        // Same row in every bank so that aliasing would show up here
        for (int b = 0; b < NUM_BANKS; b++) begin
            w = 20 * NUM_BANKS + b;
            single_access(PORT_EXEC, 1'b1, addr_of(w), $urandom());
            order.push_back(w);
        end
        for (int i = 0; i < 12; i++) begin
            w = $urandom_range(WORDS_PER_BANK - 1) * NUM_BANKS + (i % NUM_BANKS);
            single_access((i % 2) ? PORT_FETCH : PORT_EXEC, 1'b1, addr_of(w), $urandom());
            order.push_back(w);
        end
        for (int i = order.size() - 1; i >= 0; i--) begin
            single_access(PORT_FETCH, 1'b0, addr_of(order[i]), '0);
        end
    endtask

    task automatic stalled_request();
        addr_t target;
        data_t kept;
        logic  fetch_seen;
        target     = addr_of(150);
        kept       = $urandom();
        fetch_seen = 1'b0;
        single_access(PORT_EXEC, 1'b1, target, kept);
        wait_idle();
        drive_port(PORT_FETCH, 1'b1, 1'b0, addr_of(17), '0);
        @(posedge clk_i);
        #1;
        drive_port(PORT_FETCH, 1'b0, 1'b0, '0, '0);
        requests_issued++;
        require_that(stall, "stall did not rise after a fetch request");
        // Write raised under stall must be dropped
        drive_port(PORT_EXEC, 1'b1, 1'b1, target, ~kept);
        @(posedge clk_i);
        #1;
        drive_port(PORT_EXEC, 1'b0, 1'b0, '0, '0);
        while (stall) begin
            @(posedge clk_i);
            #1;
            check_bit("exec_rvalid", exec_rvalid, 1'b0);
            if (fetch_rvalid) begin
                fetch_seen = 1'b1;
                check_data("fetch_rdata", fetch_rdata, expected_word(addr_of(17)));
            end
        end
        require_that(fetch_seen, "fetch read under back-pressure returned no rvalid");
        single_access(PORT_EXEC, 1'b0, target, '0);
    endtask

    // Budget grows with every request issued
    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk_i);
            cycles++;
            if (cycles > RESET_CYCLES + CYCLES_PER_REQ * (requests_issued + 1)) begin
                $display("Run timed out after %0d cycles with %0d requests issued",
                         cycles, requests_issued);
                abort_run();
            end
        end
    end

    initial begin
        void'($urandom(32'ha1c945ee));
        reset = 1'b1;
        drive_port(PORT_FETCH, 1'b0, 1'b0, '0, '0);
        drive_port(PORT_EXEC, 1'b0, 1'b0, '0, '0);
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        reset = 1'b0;
        reset_state();
        one_port_traffic(PORT_FETCH, '{3, 17, 42, 100, 201, 255});
        one_port_traffic(PORT_EXEC, '{5, 64, 77, 130, 190, 254});
        double_requests();
        bank_spread();
        stalled_request();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: mem_subsystem.sv
// Main-memory subsystem top level, controller, bank decoder, banks and response stage

module mem_subsystem import mem_pkg::*; #(
    parameter int NUM_BANKS      = 4,
    parameter int WORDS_PER_BANK = 64,
    parameter int BANK_WAIT      = 2
) (
    input  logic  clk_i,
    input  logic  reset,
    // Fetch port
    input  logic  fetch_req,
    input  logic  fetch_we,
    input  addr_t fetch_addr,
    input  data_t fetch_wdata,
    output data_t fetch_rdata,
    output logic  fetch_rvalid,
    // Execute port
    input  logic  exec_req,
    input  logic  exec_we,
    input  addr_t exec_addr,
    input  data_t exec_wdata,
    output data_t exec_rdata,
    output logic  exec_rvalid,
    // Core stall
    output logic  stall
);

    mem_bus_if mem_bus (.clk_i(clk_i), .reset(reset));
    bank_if #(.WORDS_PER_BANK(WORDS_PER_BANK)) bank_bus [NUM_BANKS] ();

    mem_controller u_ctrl (
        .clk_i        (clk_i),
        .reset        (reset),
        .fetch_req    (fetch_req),
        .fetch_we     (fetch_we),
        .fetch_addr   (fetch_addr),
        .fetch_wdata  (fetch_wdata),
        .fetch_rdata  (fetch_rdata),
        .fetch_rvalid (fetch_rvalid),
        .exec_req     (exec_req),
        .exec_we      (exec_we),
        .exec_addr    (exec_addr),
        .exec_wdata   (exec_wdata),
        .exec_rdata   (exec_rdata),
        .exec_rvalid  (exec_rvalid),
        .stall        (stall),
        .mem          (mem_bus.controller)
    );

    bank_decoder #(
        .NUM_BANKS      (NUM_BANKS),
        .WORDS_PER_BANK (WORDS_PER_BANK)
    ) u_dec (
        .mem   (mem_bus.decoder),
        .banks (bank_bus)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        memory_bank #(
            .WORDS_PER_BANK (WORDS_PER_BANK),
            .BANK_WAIT      (BANK_WAIT)
        ) u_bank (
            .clk_i (clk_i),
            .reset (reset),
            .bus   (bank_bus[b])
        );
    end

    bank_response #(.NUM_BANKS(NUM_BANKS)) u_resp (
        .clk_i (clk_i),
        .reset (reset),
        .banks (bank_bus),
        .mem   (mem_bus.response)
    );

endmodule

// File: bank_response.sv
// Response stage, merges bank acknowledges and read data into one registered reply

module bank_response import mem_pkg::*; #(
    parameter int NUM_BANKS = 4
) (
    input logic         clk_i,
    input logic         reset,
    bank_if.response    banks [NUM_BANKS],
    mem_bus_if.response mem
);

    logic [NUM_BANKS-1:0] ack_vec;
    data_t                masked_rdata [NUM_BANKS];
    data_t                merged_rdata;
    logic                 ready_r;
    data_t                rdata_r;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_collect
        assign ack_vec[b]      = banks[b].ack;
        assign masked_rdata[b] = banks[b].ack ? banks[b].rdata : '0;
    end

    // At most one bank answers, so OR-ing the masked words selects it
    always_comb begin
        merged_rdata = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            merged_rdata = merged_rdata | masked_rdata[b];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset) ready_r <= 1'b0;
        else ready_r <= |ack_vec;
    end

    always_ff @(posedge clk_i) begin
        if (|ack_vec) rdata_r <= merged_rdata;
    end

    assign mem.ready = ready_r;
    assign mem.rdata = rdata_r;

    a_single_ack: assert property (@(posedge clk_i) disable iff (reset)
        $onehot0(ack_vec));

endmodule

// File: memory_bank.sv
// Memory bank, word storage with a fixed number of wait cycles before acknowledge

module memory_bank import mem_pkg::*; #(
    parameter int WORDS_PER_BANK = 64,
    parameter int BANK_WAIT      = 2
) (
    input logic clk_i,
    input logic reset,
    bank_if.bank bus
);

    localparam int IDX_W = $clog2(WORDS_PER_BANK);
    localparam int CNT_W = (BANK_WAIT > 1) ? $clog2(BANK_WAIT) : 1;

    bank_state_e      state_r;
    logic [CNT_W-1:0] cnt_r;
    logic             ack_r;

    // Latched request and read result
    logic [IDX_W-1:0] index_r;
    data_t            wdata_r;
    logic             we_r;
    data_t            rdata_r;

    data_t storage [WORDS_PER_BANK];

    // Operands come straight from the bus when there are no wait cycles
    logic             fire;
    logic [IDX_W-1:0] op_index;
    data_t            op_wdata;
    logic             op_we;

    assign fire     = (state_r == BK_COUNT) ? (cnt_r == '0) : (BANK_WAIT == 0 && bus.sel);
    assign op_index = (state_r == BK_COUNT) ? index_r : bus.index;
    assign op_wdata = (state_r == BK_COUNT) ? wdata_r : bus.wdata;
    assign op_we    = (state_r == BK_COUNT) ? we_r : bus.we;

    //////////////////////////////////////////////////
    // Wait counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset) begin
            state_r <= BK_IDLE;
            cnt_r   <= '0;
            ack_r   <= 1'b0;
        end else begin
            ack_r <= fire;
            unique case (state_r)
                BK_IDLE: begin
                    if (bus.sel && BANK_WAIT != 0) begin
                        state_r <= BK_COUNT;
                        cnt_r   <= CNT_W'(BANK_WAIT - 1);
                    end
                end
                BK_COUNT: begin
                    if (cnt_r == '0) state_r <= BK_IDLE;
                    else cnt_r <= cnt_r - 1'b1;
                end
            endcase
        end
    end

    // Storage and payload
    always_ff @(posedge clk_i) begin
        if (state_r == BK_IDLE && bus.sel) begin
            index_r <= bus.index;
            wdata_r <= bus.wdata;
            we_r    <= bus.we;
        end
        if (fire) begin
            if (op_we) storage[op_index] <= op_wdata;
            else rdata_r <= storage[op_index];
        end
    end

    assign bus.ack   = ack_r;
    assign bus.rdata = rdata_r;

    a_no_sel_while_busy: assert property (@(posedge clk_i) disable iff (reset)
        bus.sel |-> (state_r == BK_IDLE));

endmodule

// File: bank_decoder.sv
// Bank decoder, spreads word addresses over the banks and forwards the request

module bank_decoder import mem_pkg::*; #(
    parameter int NUM_BANKS      = 4,
    parameter int WORDS_PER_BANK = 64
) (
    mem_bus_if.decoder mem,
    bank_if.decoder    banks [NUM_BANKS]
);

    localparam int BANK_W      = $clog2(NUM_BANKS);
    localparam int IDX_W       = $clog2(WORDS_PER_BANK);
    localparam int WORD_W      = ADDR_W - BYTE_OFFSET_W;
    localparam int TOTAL_WORDS = NUM_BANKS * WORDS_PER_BANK;

    logic [WORD_W-1:0] word_addr;
    logic [BANK_W-1:0] bank_sel;
    logic [IDX_W-1:0]  bank_index;

    // Low word bits pick the bank, so neighbouring words land in different banks
    assign word_addr  = mem.addr[ADDR_W-1:BYTE_OFFSET_W];
    assign bank_sel   = word_addr[BANK_W-1:0];
    assign bank_index = word_addr[BANK_W +: IDX_W];

    //////////////////////////////////////////////////
    // Per-bank request
    //////////////////////////////////////////////////

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign banks[b].sel   = mem.valid && (bank_sel == BANK_W'(b));
        assign banks[b].we    = mem.we;
        assign banks[b].index = bank_index;
        assign banks[b].wdata = mem.wdata;
    end

    // Requester must stay inside the populated memory
    a_addr_in_range: assert property (@(posedge mem.clk_i) disable iff (mem.reset)
        mem.valid |-> (word_addr < WORD_W'(TOTAL_WORDS)));

endmodule

// File: mem_controller.sv
// Two-port memory request arbiter with held second request, core stall and read return

module mem_controller import mem_pkg::*; (
    input  logic  clk_i,
    input  logic  reset,
    // Fetch port
    input  logic  fetch_req,
    input  logic  fetch_we,
    input  addr_t fetch_addr,
    input  data_t fetch_wdata,
    output data_t fetch_rdata,
    output logic  fetch_rvalid,
    // Execute port
    input  logic  exec_req,
    input  logic  exec_we,
    input  addr_t exec_addr,
    input  data_t exec_wdata,
    output data_t exec_rdata,
    output logic  exec_rvalid,
    // Core stall
    output logic  stall,
    // Memory side
    mem_bus_if.controller mem
);

    //////////////////////////////////////////////////
    // State and registers
    //////////////////////////////////////////////////

    ctrl_state_e state_r, state_next;
    port_e       owner_r, owner_next;

    // Fetch request parked during a double request
    logic  second_r, second_next;
    addr_t second_addr_r, second_addr_next;
    data_t second_wdata_r, second_wdata_next;
    logic  second_we_r, second_we_next;

    // Access currently on the memory bus
    logic  valid_r, valid_next;
    logic  we_r, we_next;
    addr_t addr_r, addr_next;
    data_t wdata_r, wdata_next;

    // Read return toward the ports
    data_t fetch_rdata_r, fetch_rdata_next;
    logic  fetch_rvalid_r, fetch_rvalid_next;
    data_t exec_rdata_r, exec_rdata_next;
    logic  exec_rvalid_r, exec_rvalid_next;

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    always_comb begin
        state_next        = state_r;
        owner_next        = owner_r;
        second_next       = second_r;
        second_addr_next  = second_addr_r;
        second_wdata_next = second_wdata_r;
        second_we_next    = second_we_r;
        valid_next        = 1'b0;
        we_next           = we_r;
        addr_next         = addr_r;
        wdata_next        = wdata_r;
        fetch_rdata_next  = fetch_rdata_r;
        fetch_rvalid_next = 1'b0;
        exec_rdata_next   = exec_rdata_r;
        exec_rvalid_next  = 1'b0;

        unique case (state_r)
            ST_IDLE: begin
                // Execute port wins, fetch waits in the second slot
                if (exec_req) begin
                    state_next = ST_WAIT;
                    owner_next = PORT_EXEC;
                    valid_next = 1'b1;
                    we_next    = exec_we;
                    addr_next  = exec_addr;
                    wdata_next = exec_wdata;
                    if (fetch_req) begin
                        second_next       = 1'b1;
                        second_addr_next  = fetch_addr;
                        second_wdata_next = fetch_wdata;
                        second_we_next    = fetch_we;
                    end
                end else if (fetch_req) begin
                    state_next = ST_WAIT;
                    owner_next = PORT_FETCH;
                    valid_next = 1'b1;
                    we_next    = fetch_we;
                    addr_next  = fetch_addr;
                    wdata_next = fetch_wdata;
                end
            end

            ST_WAIT: begin
                if (mem.ready) begin
                    if (!we_r) begin
                        if (owner_r == PORT_EXEC) begin
                            exec_rdata_next  = mem.rdata;
                            exec_rvalid_next = 1'b1;
                        end else begin
                            fetch_rdata_next  = mem.rdata;
                            fetch_rvalid_next = 1'b1;
                        end
                    end
                    if (second_r) begin
                        // Parked fetch goes out right after the first reply
                        second_next = 1'b0;
                        owner_next  = PORT_FETCH;
                        valid_next  = 1'b1;
                        we_next     = second_we_r;
                        addr_next   = second_addr_r;
                        wdata_next  = second_wdata_r;
                    end else begin
                        state_next = ST_IDLE;
                    end
                end
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset) begin
            state_r        <= ST_IDLE;
            owner_r        <= PORT_FETCH;
            second_r       <= 1'b0;
            valid_r        <= 1'b0;
            fetch_rvalid_r <= 1'b0;
            exec_rvalid_r  <= 1'b0;
        end else begin
            state_r        <= state_next;
            owner_r        <= owner_next;
            second_r       <= second_next;
            valid_r        <= valid_next;
            fetch_rvalid_r <= fetch_rvalid_next;
            exec_rvalid_r  <= exec_rvalid_next;
        end
    end

    always_ff @(posedge clk_i) begin
        second_addr_r  <= second_addr_next;
        second_wdata_r <= second_wdata_next;
        second_we_r    <= second_we_next;
        we_r           <= we_next;
        addr_r         <= addr_next;
        wdata_r        <= wdata_next;
        fetch_rdata_r  <= fetch_rdata_next;
        exec_rdata_r   <= exec_rdata_next;
    end

    assign stall        = (state_r == ST_WAIT);
    assign mem.valid    = valid_r;
    assign mem.we       = we_r;
    assign mem.addr     = addr_r;
    assign mem.wdata    = wdata_r;
    assign fetch_rdata  = fetch_rdata_r;
    assign fetch_rvalid = fetch_rvalid_r;
    assign exec_rdata   = exec_rdata_r;
    assign exec_rvalid  = exec_rvalid_r;

    // No new access until the memory side has answered the last one
    a_single_outstanding: assert property (@(posedge clk_i) disable iff (reset)
        mem.valid |=> (!mem.valid until_with mem.ready));

    a_rvalid_exclusive: assert property (@(posedge clk_i) disable iff (reset)
        !(fetch_rvalid && exec_rvalid));

endmodule

// File: mem_bus_if.sv
// Interfaces mem_bus_if (controller to memory side) and bank_if (per-bank link)

interface mem_bus_if import mem_pkg::*; (
    input logic clk_i,
    input logic reset
);
    logic  valid;
    logic  we;
    addr_t addr;
    data_t wdata;
    logic  ready;
    data_t rdata;

    modport controller (output valid, we, addr, wdata, input ready, rdata);
    modport decoder (input clk_i, reset, valid, we, addr, wdata);
    modport response (output ready, rdata);
endinterface

interface bank_if import mem_pkg::*; #(
    parameter int WORDS_PER_BANK = 64
) ();
    localparam int IDX_W = $clog2(WORDS_PER_BANK);

    logic             sel;
    logic             we;
    logic [IDX_W-1:0] index;
    data_t            wdata;
    logic             ack;
    data_t            rdata;

    modport decoder (output sel, we, index, wdata);
    modport bank (input sel, we, index, wdata, output ack, rdata);
    modport response (input ack, rdata);
endinterface

// File: mem_pkg.sv
// Shared widths, state enums, served-port type and word/address types

package mem_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    // One data word
    localparam int DATA_W = 32;

    // Byte address as seen by the cache controllers
    localparam int ADDR_W = 32;

    // Low address bits that select a byte inside a word
    localparam int BYTE_OFFSET_W = $clog2(DATA_W / 8);

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Controller FSM
    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_WAIT = 1'b1
    } ctrl_state_e;

    // Bank FSM, counts wait cycles before the access
    typedef enum logic {
        BK_IDLE  = 1'b0,
        BK_COUNT = 1'b1
    } bank_state_e;

    // Owner of the access in flight
    typedef enum logic {
        PORT_FETCH = 1'b0,
        PORT_EXEC  = 1'b1
    } port_e;

endpackage
